// File: Makefile
# Verilator simulation of the accelerator subsystem testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f compile.f --top-module tb_accelerator_subsystem \
		-Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	@if grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: adc_wrapper/adc_apb_regs.sv
// APB register file with control, status, sample pop and level interrupt
`timescale 1ns/1ns
`default_nettype none

`include "acc_defines.svh"

module adc_apb_regs
  import adc_pkg::*;
(
  input  wire                       hclk,
  input  wire                       rst_n,
  // APB slave
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  wire [`ACC_ADDR_W-1:0]     paddr,
  input  wire [`ACC_DATA_W-1:0]     pwdata,
  output logic [`ACC_DATA_W-1:0]    prdata,
  output logic                      pready,
  // FIFO read side
  input  wire                       m_valid,
  input  wire [SAMPLE_W-1:0]        m_data,
  input  wire [`FIFO_LEVEL_W-1:0]   level,
  output logic                      m_ready,
  // Sampler control
  input  wire                       overrun,
  output logic                      enable,
  output logic [DECIM_W-1:0]        decim,
  output logic                      overrun_clr,
  // Interrupt
  output logic                      irq
);

  reg_addr_e                  sel;
  logic                       wr_en;
  logic                       rd_en;
  logic                       irq_en;
  logic [`FIFO_LEVEL_W-1:0]   thresh;

  // --------------------
  // Address decode
  // Full decode so aliases read as unmapped
  always_comb begin
    case (paddr)
      `REG_CTRL:   sel = SEL_CTRL;
      `REG_STATUS: sel = SEL_STATUS;
      `REG_DATA:   sel = SEL_DATA;
      `REG_IRQ:    sel = SEL_IRQ;
      default:     sel = SEL_NONE;
    endcase
  end

  // Access phase qualifiers
  assign wr_en = psel & penable & pwrite;
  assign rd_en = psel & penable & ~pwrite;

  // No wait states
  assign pready = 1'b1;

  // --------------------
  // Writable registers
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      enable <= 1'b0;
      decim  <= '0;
      irq_en <= 1'b0;
      thresh <= '0;
    end else if (wr_en) begin
      if (sel == SEL_CTRL) begin
        enable <= pwdata[0];
        decim  <= pwdata[7:4];
      end
      if (sel == SEL_IRQ) begin
        irq_en <= pwdata[0];
        thresh <= pwdata[7:4];
      end
    end
  end

  // Write one to STATUS bit 8 clears overrun
  assign overrun_clr = wr_en & (sel == SEL_STATUS) & pwdata[8];

  // Pop only when a sample is there
  assign m_ready = rd_en & (sel == SEL_DATA) & m_valid;

  // --------------------
  // Read mux
  always_comb begin
    prdata = '0;
    case (sel)
      SEL_CTRL: begin
        prdata[0]   = enable;
        prdata[7:4] = decim;
      end
      SEL_STATUS: begin
        prdata[3:0] = level;
        prdata[4]   = (level == '0);
        prdata[8]   = overrun;
      end
      // Empty FIFO reads as zero
      SEL_DATA: begin
        if (m_valid) begin
          prdata[SMP_DATA_MSB:0] = m_data[SMP_DATA_MSB:SMP_DATA_LSB];
          prdata[REG_CHAN_LSB +: `ADC_CHAN_W] = m_data[SMP_CHAN_MSB:SMP_CHAN_LSB];
        end
      end
      SEL_IRQ: begin
        prdata[0]   = irq_en;
        prdata[7:4] = thresh;
      end
      default: begin
        prdata = '0;
      end
    endcase
  end

  // --------------------
  // Level interrupt, one cycle behind the level
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      irq <= 1'b0;
    end else begin
      irq <= irq_en & (level >= thresh);
    end
  end

endmodule

`default_nettype wire

// File: adc_wrapper/adc_sampler.sv
// ADC sampler with strobe decimation, channel tagging and sticky overrun
`timescale 1ns/1ns
`default_nettype none

`include "acc_defines.svh"

module adc_sampler
  import adc_pkg::*;
(
  input  wire                      hclk,
  input  wire                      rst_n,
  // External converter
  input  wire                      adc_strobe,
  input  wire [`ADC_SAMPLE_W-1:0]  adc_data,
  input  wire [`ADC_CHAN_W-1:0]    adc_chan,
  // Control from registers
  input  wire                      enable,
  input  wire [DECIM_W-1:0]        decim,
  input  wire                      overrun_clr,
  // Valid/ready to the FIFO
  input  wire                      s_ready,
  output logic                     s_valid,
  output logic [SAMPLE_W-1:0]      s_data,
  output logic                     overrun
);

  logic                en_q;
  logic                en_rise;
  logic [DECIM_W-1:0]  cnt;
  logic [DECIM_W-1:0]  cnt_eff;
  logic                keep;
  logic                stall;

  // --------------------
  // Decimation
  // Counter restarts on the cycle enable rises
  assign en_rise = enable & ~en_q;
  assign cnt_eff = en_rise ? '0 : cnt;

  // Keep the strobe at count zero
  assign keep = adc_strobe & enable & (cnt_eff == '0);

  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      en_q <= 1'b0;
      cnt  <= '0;
    end else begin
      en_q <= enable;
      if (adc_strobe && enable) begin
        // Wrap after decim+1 strobes, also if decim shrank
        cnt <= (cnt_eff >= decim) ? '0 : cnt_eff + DECIM_W'(1);
      end else if (en_rise) begin
        cnt <= '0;
      end
    end
  end

  // --------------------
  // Output slot
  // Still waiting means offered but not taken
  assign stall = s_valid & ~s_ready;

  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      s_valid <= 1'b0;
    end else if (keep && !stall) begin
      s_valid <= 1'b1;
    end else if (s_ready) begin
      s_valid <= 1'b0;
    end
  end

  // Tagged word loaded only into a free slot
  always_ff @(posedge hclk) begin
    if (keep && !stall) begin
      s_data[SMP_CHAN_MSB:SMP_CHAN_LSB] <= adc_chan;
      s_data[SMP_DATA_MSB:SMP_DATA_LSB] <= adc_data;
    end
  end

  // Sticky loss flag, a new loss wins over the clear
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      overrun <= 1'b0;
    end else if (keep && stall) begin
      overrun <= 1'b1;
    end else if (overrun_clr) begin
      overrun <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: adc_wrapper/sample_fifo.sv
// Synchronous sample FIFO with valid/ready on both sides and a fill level
`timescale 1ns/1ns
`default_nettype none

`include "acc_defines.svh"

module sample_fifo
  import adc_pkg::*;
(
  input  wire                       hclk,
  input  wire                       rst_n,
  // Write side from the sampler
  input  wire                       s_valid,
  input  wire [SAMPLE_W-1:0]        s_data,
  output logic                      s_ready,
  // Read side to the registers
  input  wire                       m_ready,
  output logic                      m_valid,
  output logic [SAMPLE_W-1:0]       m_data,
  output logic [`FIFO_LEVEL_W-1:0]  level
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);

  logic [SAMPLE_W-1:0]  mem [`FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic                 push;
  logic                 pop;

  // Circular pointer step
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  // --------------------
  // Handshakes
  // Full stalls the sampler
  assign s_ready = (level != `FIFO_LEVEL_W'(`FIFO_DEPTH));
  assign m_valid = (level != '0);
  assign push    = s_valid & s_ready;
  assign pop     = m_valid & m_ready;

  // Head of queue
  assign m_data = mem[rd_ptr];

  // Pointers and level, push and pop may coincide
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10:   level <= level + `FIFO_LEVEL_W'(1);
        2'b01:   level <= level - `FIFO_LEVEL_W'(1);
        default: level <= level;
      endcase
    end
  end

  // Storage
  always_ff @(posedge hclk) begin
    if (push) begin
      mem[wr_ptr] <= s_data;
    end
  end

endmodule

`default_nettype wire

// File: common/acc_defines.svh
// Bus widths, sample and FIFO sizing, and APB register offsets for the accelerator
`ifndef ACC_DEFINES_SVH
`define ACC_DEFINES_SVH

// --------------------
// Bus widths
// AHB address as seen by the host
`define ACC_HADDR_W 32
// Shared AHB and APB data width
`define ACC_DATA_W 32
// APB address into the sensor block
`define ACC_ADDR_W 16

// --------------------
// Converter sample
`define ADC_SAMPLE_W 12
`define ADC_CHAN_W 2

// --------------------
// Sample FIFO
`define FIFO_DEPTH 8
// Must hold 0 to FIFO_DEPTH inclusive
`define FIFO_LEVEL_W 4

// --------------------
// Register offsets in the APB window
`define REG_CTRL 'h0
`define REG_STATUS 'h4
`define REG_DATA 'h8
`define REG_IRQ 'hC

`endif

// File: common/adc_pkg.sv
// Sensor block register selector and sample word field layout
`default_nettype none

`include "acc_defines.svh"

package adc_pkg;

  // --------------------
  // Register selector after address decode
  typedef enum logic [2:0] {
    SEL_CTRL   = 3'd0,
    SEL_STATUS = 3'd1,
    SEL_DATA   = 3'd2,
    SEL_IRQ    = 3'd3,
    SEL_NONE   = 3'd4
  } reg_addr_e;

  // --------------------
  // Sample word, channel on top of data
  localparam int SAMPLE_W     = `ADC_CHAN_W + `ADC_SAMPLE_W;
  localparam int SMP_DATA_LSB = 0;
  localparam int SMP_DATA_MSB = `ADC_SAMPLE_W - 1;
  localparam int SMP_CHAN_LSB = `ADC_SAMPLE_W;
  localparam int SMP_CHAN_MSB = SAMPLE_W - 1;

  // Channel position in the DATA register view
  localparam int REG_CHAN_LSB = 16;

  // Decimation factor width in CTRL
  localparam int DECIM_W = 4;

endpackage

`default_nettype wire

// File: common/bus_pkg.sv
// AHB transfer type and AHB to APB bridge state encodings
`default_nettype none

package bus_pkg;

  // --------------------
  // AHB-Lite HTRANS encoding
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // --------------------
  // Bridge sequencing
  // Idle waits for an AHB address phase
  // Setup drives psel alone, access adds penable
  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,
    ST_SETUP  = 2'b01,
    ST_ACCESS = 2'b10
  } bridge_state_e;

endpackage

`default_nettype wire

// File: compile.f
+incdir+common
+incdir+dv
common/bus_pkg.sv
common/adc_pkg.sv
verilog/ahb_to_apb_bridge.sv
adc_wrapper/adc_sampler.sv
adc_wrapper/sample_fifo.sv
adc_wrapper/adc_apb_regs.sv
verilog/accelerator_subsystem.sv
dv/tb_accelerator_subsystem.sv

// File: dv/tb_ahb_tasks.svh
// AHB-Lite write and read tasks and the converter strobe task for the testbench top

// --------------------
// AHB-Lite host side
// Every task starts and ends on a falling edge with the bridge idle

// NONSEQ address phase taken on the next rising edge
task automatic ahb_address_phase(input logic [31:0] offset, input logic write);
  hsel   = 1'b1;
  haddr  = APB_BASE | offset;
  htrans = HTRANS_NONSEQ;
  hwrite = write;
  @(negedge hclk);
  // Single transfer so the bus goes idle for the data phase
  hsel   = 1'b0;
  htrans = HTRANS_IDLE;
endtask

// Data phase ends when hreadyout comes back
// Setup and access give exactly two wait states
task automatic ahb_wait_done();
  int waits;
  waits = 0;
  while (!hreadyout) begin
    @(negedge hclk);
    waits++;
  end
  if (waits != 2) report_mismatch("AHB wait states", waits, 32'd2);
  // Response is always OKAY
  if (hresp !== 1'b0) report_mismatch("hresp", {31'h0, hresp}, 32'h0);
endtask

task automatic ahb_write(input logic [31:0] offset, input logic [31:0] data);
  ahb_address_phase(offset, 1'b1);
  // Held through setup and access
  hwdata = data;
  ahb_wait_done();
endtask

task automatic ahb_read(input logic [31:0] offset, output logic [31:0] data);
  ahb_address_phase(offset, 1'b0);
  ahb_wait_done();
  // Registered by the bridge as the access completed
  data = hrdata;
endtask

// --------------------
// Converter side
// One-cycle strobe, then a short gap so the sample lands in the FIFO
task automatic send_strobe(input logic [`ADC_SAMPLE_W-1:0] data,
                           input logic [`ADC_CHAN_W-1:0] chan);
  adc_strobe = 1'b1;
  adc_data   = data;
  adc_chan   = chan;
  @(negedge hclk);
  adc_strobe = 1'b0;
  repeat (STROBE_GAP) @(negedge hclk);
endtask

// File: dv/tb_accelerator_subsystem.sv
// Testbench top with clock, reset, LFSR stimulus, sample model, tests, watchdog and summary
`timescale 1ns/1ns
`default_nettype none

`include "acc_defines.svh"

module tb_accelerator_subsystem
  import bus_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 10;
  localparam int STROBE_GAP = 2;
  localparam logic [31:0] APB_BASE = 32'h4000_0000;

  // Rough cycle budget per test, the watchdog allows four times the sum
  localparam int TEST_CYCLES = RESET_CYCLES + 400 + 400 + 200 + 200 + 250;
  localparam int WATCHDOG_NS = TEST_CYCLES * 4 * CLK_PERIOD;

  // --------------------
  // DUT signals
  logic                       hclk;
  logic                       rst_n;
  logic                       hsel;
  logic [`ACC_HADDR_W-1:0]    haddr;
  htrans_e                    htrans;
  logic                       hwrite;
  logic                       hready;
  logic [`ACC_DATA_W-1:0]     hwdata;
  logic [2:0]                 hsize;
  logic [3:0]                 hprot;
  logic                       hreadyout;
  logic                       hresp;
  logic [`ACC_DATA_W-1:0]     hrdata;
  logic                       adc_strobe;
  logic [`ADC_SAMPLE_W-1:0]   adc_data;
  logic [`ADC_CHAN_W-1:0]     adc_chan;
  logic                       irq;

  // --------------------
  // Model state
  // Samples in flight, FIFO plus the sampler slot, as {chan, data}
  logic [13:0]  model_q[$];
  logic         model_ovr;
  logic [31:0]  shadow_ctrl;
  logic [31:0]  shadow_irq;
  int           cur_decim;
  int           strobe_idx;
  logic [31:0]  lfsr_state = 32'h05a6f1f0;

  // Bookkeeping
  int err_count = 0;
  int test_err_base = 0;
  int tests_run = 0;
  int tests_bad = 0;

  accelerator_subsystem dut0 (
    .hclk       (hclk),
    .rst_n      (rst_n),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hready     (hready),
    .hwdata     (hwdata),
    .hsize      (hsize),
    .hprot      (hprot),
    .hreadyout  (hreadyout),
    .hresp      (hresp),
    .hrdata     (hrdata),
    .adc_strobe (adc_strobe),
    .adc_data   (adc_data),
    .adc_chan   (adc_chan),
    .irq        (irq)
  );

  `include "tb_ahb_tasks.svh"

  initial begin
    hclk = 1'b0;
    forever #(CLK_PERIOD / 2) hclk = ~hclk;
  end

  // --------------------
  // Random source
  // Fibonacci LFSR x^32+x^22+x^2+x+1, one step per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = 32'h0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  // --------------------
  // Expected register views
  function automatic int model_level();
    return (model_q.size() > `FIFO_DEPTH) ? `FIFO_DEPTH : model_q.size();
  endfunction

  // Data in 11:0, channel in 17:16
  function automatic logic [31:0] data_view(input logic [13:0] smp);
    data_view = 32'h0;
    data_view[11:0] = smp[11:0];
    data_view[17:16] = smp[13:12];
  endfunction

  // Level 3:0, empty 4, overrun 8
  function automatic logic [31:0] status_view();
    int lvl;
    lvl = model_level();
    status_view = 32'h0;
    status_view[3:0] = lvl[3:0];
    status_view[4] = (lvl == 0);
    status_view[8] = model_ovr;
  endfunction

  // --------------------
  // Reporting
  task automatic report_mismatch(input string tag, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED at %0t ns: %s, got 0x%08h expected 0x%08h", $time, tag, got, exp);
    err_count++;
  endtask

  task automatic start_test();
    test_err_base = err_count;
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = err_count - test_err_base;
    tests_run++;
    if (errs == 0) begin
      $display("%s: done, no errors", name);
    end else begin
      tests_bad++;
      $display("%s: done, %0d errors", name, errs);
    end
  endtask

  // --------------------
  // Model helpers
  // Write 0 then enable so the decimation counter restarts
  task automatic restart_sampler(input int decim);
    ahb_write(`REG_CTRL, 32'h0);
    ahb_write(`REG_CTRL, (decim << 4) | 1);
    cur_decim = decim;
    strobe_idx = 0;
  endtask

  // Every (decim+1)th strobe kept, lost once FIFO and slot are both taken
  task automatic strobe_and_model();
    logic [31:0] r;
    r = rand_bits(14);
    send_strobe(r[11:0], r[13:12]);
    if ((strobe_idx % (cur_decim + 1)) == 0) begin
      if (model_q.size() < `FIFO_DEPTH + 1) begin
        model_q.push_back({r[13:12], r[11:0]});
      end else begin
        model_ovr = 1'b1;
      end
    end
    strobe_idx++;
  endtask

  task automatic pop_and_check(input string tag);
    logic [31:0] got;
    logic [31:0] exp;
    exp = 32'h0;
    if (model_q.size() > 0) begin
      exp = data_view(model_q.pop_front());
    end
    ahb_read(`REG_DATA, got);
    if (got !== exp) report_mismatch(tag, got, exp);
  endtask

  task automatic drain_and_check(input string tag);
    while (model_q.size() > 0) begin
      pop_and_check(tag);
    end
  endtask

  task automatic check_status(input string tag);
    logic [31:0] got;
    ahb_read(`REG_STATUS, got);
    if (got !== status_view()) report_mismatch(tag, got, status_view());
  endtask

  // STATUS read first so the registered irq has settled
  task automatic check_irq(input string tag);
    logic exp;
    check_status(tag);
    exp = shadow_irq[0] && (model_level() >= {28'h0, shadow_irq[7:4]});
    if (irq !== exp) report_mismatch(tag, {31'h0, irq}, {31'h0, exp});
  endtask

  // --------------------
  // Tests
  task automatic run_register_round_trip();
    logic [31:0] wval;
    logic [31:0] rval;
    logic [31:0] addr;
    start_test();
    check_status("STATUS after reset");
    for (int i = 0; i < 6; i++) begin
      wval = rand_bits(32);
      ahb_write(`REG_CTRL, wval);
      shadow_ctrl = wval & 32'h0000_00F1;
      wval = rand_bits(32);
      ahb_write(`REG_IRQ, wval);
      shadow_irq = wval & 32'h0000_00F1;
      ahb_read(`REG_CTRL, rval);
      if (rval !== shadow_ctrl) report_mismatch("CTRL read-back", rval, shadow_ctrl);
      ahb_read(`REG_IRQ, rval);
      if (rval !== shadow_irq) report_mismatch("IRQ read-back", rval, shadow_irq);
      // Word address above the register window
      addr = rand_bits(14) << 2;
      if (addr < 32'h10) addr = addr + 32'h10;
      ahb_write(addr, rand_bits(32));
      ahb_read(addr, rval);
      if (rval !== 32'h0) report_mismatch("unmapped read", rval, 32'h0);
      ahb_read(`REG_CTRL, rval);
      if (rval !== shadow_ctrl) report_mismatch("CTRL after unmapped write", rval, shadow_ctrl);
    end
    ahb_write(`REG_CTRL, 32'h0);
    ahb_write(`REG_IRQ, 32'h0);
    shadow_ctrl = 32'h0;
    shadow_irq = 32'h0;
    finish_test("register round trip");
  endtask

  task automatic run_decimation();
    int decim;
    start_test();
    decim = rand_bits(4);
    restart_sampler(decim);
    for (int i = 0; i < 20; i++) begin
      strobe_and_model();
      // Drain early so the FIFO never fills
      if (model_q.size() >= `FIFO_DEPTH - 2) drain_and_check("decimated sample");
    end
    drain_and_check("decimated sample");
    ahb_write(`REG_CTRL, 32'h0);
    finish_test("decimation and tagging");
  endtask

  task automatic run_level_empty();
    int decim;
    int kept;
    logic [31:0] got;
    start_test();
    decim = rand_bits(2);
    kept = 1 + (rand_bits(3) % 6);
    restart_sampler(decim);
    repeat (kept * (decim + 1)) strobe_and_model();
    check_status("level after strobes");
    drain_and_check("level test sample");
    check_status("level after drain");
    ahb_read(`REG_DATA, got);
    if (got !== 32'h0) report_mismatch("DATA read while empty", got, 32'h0);
    check_status("level after empty read");
    ahb_write(`REG_CTRL, 32'h0);
    finish_test("level and empty");
  endtask

  task automatic run_backpressure();
    start_test();
    restart_sampler(0);
    // At least one strobe beyond FIFO plus slot
    repeat (`FIFO_DEPTH + 2 + rand_bits(2)) strobe_and_model();
    check_status("STATUS with FIFO full");
    drain_and_check("held sample");
    check_status("STATUS after drain");
    ahb_write(`REG_STATUS, 32'h0000_0100);
    model_ovr = 1'b0;
    check_status("STATUS after overrun clear");
    ahb_write(`REG_CTRL, 32'h0);
    finish_test("back-pressure and overrun");
  endtask

  task automatic run_interrupt();
    int thresh;
    start_test();
    thresh = 1 + (rand_bits(3) % 6);
    restart_sampler(0);
    shadow_irq = (thresh << 4) | 1;
    ahb_write(`REG_IRQ, shadow_irq);
    check_irq("irq with FIFO empty");
    repeat (thresh + 1) begin
      strobe_and_model();
      check_irq("irq while filling");
    end
    while (model_q.size() > 0) begin
      pop_and_check("irq test sample");
      check_irq("irq while draining");
    end
    ahb_write(`REG_IRQ, 32'h0);
    shadow_irq = 32'h0;
    ahb_write(`REG_CTRL, 32'h0);
    finish_test("interrupt threshold");
  endtask

  // --------------------
  // Main sequence
  initial begin
    rst_n = 1'b0;
    hsel = 1'b0;
    haddr = '0;
    htrans = HTRANS_IDLE;
    hwrite = 1'b0;
    hready = 1'b1;
    hwdata = '0;
    hsize = 3'b010;
    hprot = 4'b0011;
    adc_strobe = 1'b0;
    adc_data = '0;
    adc_chan = '0;
    model_ovr = 1'b0;
    shadow_ctrl = 32'h0;
    shadow_irq = 32'h0;
    cur_decim = 0;
    strobe_idx = 0;
    repeat (RESET_CYCLES) @(negedge hclk);
    rst_n = 1'b1;
    @(negedge hclk);
    run_register_round_trip();
    run_decimation();
    run_level_empty();
    run_backpressure();
    run_interrupt();
    $display("Summary: %0d tests, %0d with errors, %0d errors in total",
             tests_run, tests_bad, err_count);
    if (err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/accelerator_subsystem.sv
// Accelerator top level with AHB to APB bridge, ADC sampler, sample FIFO and registers
`timescale 1ns/1ns
`default_nettype none

`include "acc_defines.svh"

module accelerator_subsystem
  import bus_pkg::*;
  import adc_pkg::*;
(
  input  wire                      hclk,
  input  wire                      rst_n,
  // AHB-Lite from the host
  input  wire                      hsel,
  input  wire [`ACC_HADDR_W-1:0]   haddr,
  input  wire htrans_e             htrans,
  input  wire                      hwrite,
  input  wire                      hready,
  input  wire [`ACC_DATA_W-1:0]    hwdata,
  // Size and protection are accepted but not decoded
  input  wire [2:0]                hsize,
  input  wire [3:0]                hprot,
  output logic                     hreadyout,
  output logic                     hresp,
  output logic [`ACC_DATA_W-1:0]   hrdata,
  // External converter
  input  wire                      adc_strobe,
  input  wire [`ADC_SAMPLE_W-1:0]  adc_data,
  input  wire [`ADC_CHAN_W-1:0]    adc_chan,
  // Interrupt to the SoC
  output logic                     irq
);

  // --------------------
  // APB between bridge and registers
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [`ACC_ADDR_W-1:0]   paddr;
  logic [`ACC_DATA_W-1:0]   pwdata;
  logic [`ACC_DATA_W-1:0]   prdata;
  logic                     pready;

  // Sampler into FIFO
  logic                     s_valid;
  logic                     s_ready;
  logic [SAMPLE_W-1:0]      s_data;

  // FIFO into registers
  logic                     m_valid;
  logic                     m_ready;
  logic [SAMPLE_W-1:0]      m_data;
  logic [`FIFO_LEVEL_W-1:0] level;

  // Register control back to the sampler
  logic                     enable;
  logic [DECIM_W-1:0]       decim;
  logic                     overrun_clr;
  logic                     overrun;

  ahb_to_apb_bridge u_bridge (
    .hclk      (hclk),
    .rst_n     (rst_n),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hready    (hready),
    .hwdata    (hwdata),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .hrdata    (hrdata),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .pready    (pready),
    .prdata    (prdata)
  );

  adc_sampler u_sampler (
    .hclk        (hclk),
    .rst_n       (rst_n),
    .adc_strobe  (adc_strobe),
    .adc_data    (adc_data),
    .adc_chan    (adc_chan),
    .enable      (enable),
    .decim       (decim),
    .overrun_clr (overrun_clr),
    .s_ready     (s_ready),
    .s_valid     (s_valid),
    .s_data      (s_data),
    .overrun     (overrun)
  );

  sample_fifo u_fifo (
    .hclk    (hclk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_data  (s_data),
    .m_ready (m_ready),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_data  (m_data),
    .level   (level)
  );

  adc_apb_regs u_regs (
    .hclk        (hclk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .m_valid     (m_valid),
    .m_data      (m_data),
    .level       (level),
    .overrun     (overrun),
    .prdata      (prdata),
    .pready      (pready),
    .m_ready     (m_ready),
    .enable      (enable),
    .decim       (decim),
    .overrun_clr (overrun_clr),
    .irq         (irq)
  );

endmodule

`default_nettype wire

// File: verilog/ahb_to_apb_bridge.sv
// AHB-Lite slave sequencing each host access into one APB setup and access phase
`timescale 1ns/1ns
`default_nettype none

`include "acc_defines.svh"

module ahb_to_apb_bridge
  import bus_pkg::*;
(
  input  wire                     hclk,
  input  wire                     rst_n,
  // AHB-Lite slave side
  input  wire                     hsel,
  input  wire [`ACC_HADDR_W-1:0]  haddr,
  input  wire htrans_e            htrans,
  input  wire                     hwrite,
  input  wire                     hready,
  input  wire [`ACC_DATA_W-1:0]   hwdata,
  output logic                    hreadyout,
  output logic                    hresp,
  output logic [`ACC_DATA_W-1:0]  hrdata,
  // APB master side
  output logic                    psel,
  output logic                    penable,
  output logic                    pwrite,
  output logic [`ACC_ADDR_W-1:0]  paddr,
  output logic [`ACC_DATA_W-1:0]  pwdata,
  input  wire                     pready,
  input  wire [`ACC_DATA_W-1:0]   prdata
);

  bridge_state_e           state;
  logic                    xfer_req;
  logic                    accept;
  logic                    write_q;
  logic [`ACC_ADDR_W-1:0]  addr_q;

  // --------------------
  // Address phase detection
  // Only NONSEQ and SEQ carry a real transfer
  assign xfer_req = hsel && hready &&
                    ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  // New transfer taken only from idle
  assign accept = (state == ST_IDLE) && xfer_req;

  // --------------------
  // Transfer sequencer
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_SETUP;
          end
        end
        // Setup always lasts one cycle
        ST_SETUP: begin
          state <= ST_ACCESS;
        end
        // Hold access until the slave completes
        ST_ACCESS: begin
          if (pready) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Address and direction latched in the AHB address phase
  // Upper haddr bits select the subsystem and are dropped here
  always_ff @(posedge hclk) begin
    if (accept) begin
      addr_q  <= haddr[`ACC_ADDR_W-1:0];
      write_q <= hwrite;
    end
  end

  // Read data captured as the access phase completes
  always_ff @(posedge hclk) begin
    if ((state == ST_ACCESS) && pready && !write_q) begin
      hrdata <= prdata;
    end
  end

  // --------------------
  // APB drive
  assign psel    = (state == ST_SETUP) || (state == ST_ACCESS);
  assign penable = (state == ST_ACCESS);
  assign pwrite  = write_q;
  assign paddr   = addr_q;

  // Host keeps hwdata stable over the whole stretched data phase
  assign pwdata = hwdata;

  // --------------------
  // AHB response
  // Wait states cover setup and access
  assign hreadyout = (state == ST_IDLE);

  // Always OKAY
  assign hresp = 1'b0;

endmodule

`default_nettype wire
